/* l15_adapter_settings.svh */
/*
  Build-time constants of the L1.5 adapter.
  Widths are shared by both packages, the RTL and the testbench.
  The size codes are log2 of the access size in bytes.
*/
`ifndef L15_ADAPTER_SETTINGS_SVH
`define L15_ADAPTER_SETTINGS_SVH

// Port 0 ifill read, port 1 dcache read, port 2 dcache write
`define L15_N_PORTS   3
`define L15_PID_W     2
`define L15_TID_W     4

`define L15_ADDR_W    40
`define L15_DATA_W    64

// Size codes for a 32-byte line and an 8-byte word
`define L15_SIZE_W    3
`define L15_SIZE_LINE 3'd5
`define L15_SIZE_WORD 3'd3

`endif

/* mem_req_pkg.sv */
/*
  Cache-side request and response types.
  Write data travels inside the request, so there is no separate data channel.
  Every port returns the same response shape.
*/
`include "l15_adapter_settings.svh"

package mem_req_pkg;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_cmd_e;

  // One request as held in a port slot
  typedef struct packed {
    mem_cmd_e                cmd;
    logic [`L15_ADDR_W-1:0]  addr;
    logic                    nc;
    logic [`L15_TID_W-1:0]   tid;
    logic [`L15_DATA_W-1:0]  wdata;
  } mem_req_t;

  // One response, pid selects the destination port
  typedef struct packed {
    logic [`L15_PID_W-1:0]   pid;
    logic [`L15_TID_W-1:0]   tid;
    logic [`L15_DATA_W-1:0]  rdata;
    logic                    error;
  } mem_resp_t;

endpackage

/* l15_pkg.sv */
/*
  L1.5-side request type and transaction tag.
  The tag carries the source port id in its upper bits so that
  returns can be routed without any lookup table.
*/
`include "l15_adapter_settings.svh"

package l15_pkg;

  typedef enum logic {
    L15_LOAD  = 1'b0,
    L15_STORE = 1'b1
  } l15_rqtype_e;

  // Echoed unchanged by the L1.5 on the return channel
  typedef struct packed {
    logic [`L15_PID_W-1:0] pid;
    logic [`L15_TID_W-1:0] tid;
  } l15_tag_t;

endpackage

/* mem_fifo_reg.sv */
/*
  One-deep register slot with a valid/ready style handshake.
  Writes are taken only while empty; there is no bypass, so a full slot
  keeps wok_o low until it is read. The payload register has no reset.
*/
`timescale 1ns/1ps

module mem_fifo_reg #(
  parameter type fifo_data_t = logic
) (
  input  logic       clk_i,
  input  logic       arst_n_i,

  input  logic       w_i,
  output logic       wok_o,
  input  fifo_data_t wdata_i,

  input  logic       r_i,
  output logic       rok_o,
  output fifo_data_t rdata_o
);

  logic       full_q;
  fifo_data_t data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (w_i && !full_q) begin
      full_q <= 1'b1;
    end else if (r_i && full_q) begin
      // Freed on the read edge, refilled no earlier than the next one
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_i && !full_q) begin
      data_q <= wdata_i;
    end
  end

  assign wok_o   = ~full_q;
  assign rok_o   = full_q;
  assign rdata_o = data_q;

endmodule

/* l15_req_arbiter.sv */
/*
  Round-robin choice among the request slots.
  The slot after the last granted one has the highest priority.
  A stalled grant is locked until accepted, so the output stays stable
  even when other slots fill in the meantime.
*/
`timescale 1ns/1ps
`include "l15_adapter_settings.svh"

module l15_req_arbiter (
  input  logic                   clk_i,
  input  logic                   arst_n_i,

  input  logic                   slot_valid_i [`L15_N_PORTS],
  input  mem_req_pkg::mem_req_t  slot_req_i   [`L15_N_PORTS],
  output logic                   slot_pop_o   [`L15_N_PORTS],

  output logic                   grant_valid_o,
  output mem_req_pkg::mem_req_t  grant_req_o,
  output logic [`L15_PID_W-1:0]  grant_pid_o,
  input  logic                   grant_ready_i
);

  localparam int N     = `L15_N_PORTS;
  localparam int PID_W = `L15_PID_W;

  logic [PID_W-1:0] last_q;
  logic [PID_W-1:0] lock_idx_q;
  logic             lock_q;
  logic [PID_W-1:0] pick;
  logic             pick_valid;
  logic [PID_W-1:0] sel;

  // Walk from lowest to highest priority so the nearest valid slot wins
  always_comb begin
    pick       = last_q;
    pick_valid = 1'b0;
    for (int i = N; i >= 1; i--) begin
      if (slot_valid_i[(int'(last_q) + i) % N]) begin
        pick       = PID_W'((int'(last_q) + i) % N);
        pick_valid = 1'b1;
      end
    end
  end

  assign sel           = lock_q ? lock_idx_q : pick;
  assign grant_valid_o = lock_q | pick_valid;
  assign grant_req_o   = slot_req_i[sel];
  assign grant_pid_o   = sel;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      slot_pop_o[i] = grant_valid_o && grant_ready_i && (sel == PID_W'(i));
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // Port 0 comes first after reset
      last_q     <= PID_W'(N - 1);
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (grant_valid_o) begin
      if (grant_ready_i) begin
        last_q <= sel;
        lock_q <= 1'b0;
      end else begin
        lock_q     <= 1'b1;
        lock_idx_q <= sel;
      end
    end
  end

endmodule

/* l15_xlate.sv */
/*
  Translation between the cache request format and the L1.5 channel.
  Requests pass through combinationally, so the L1.5 sees the grant
  in the cycle it is made. Returns are decoded from the echoed tag;
  the L1.5 must echo it unchanged.
*/
`timescale 1ns/1ps
`include "l15_adapter_settings.svh"

module l15_xlate (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  input  logic                      grant_valid_i,
  input  mem_req_pkg::mem_req_t     grant_req_i,
  input  logic [`L15_PID_W-1:0]     grant_pid_i,
  output logic                      grant_ready_o,

  output logic                      l15_req_valid_o,
  input  logic                      l15_req_ready_i,
  output l15_pkg::l15_rqtype_e      l15_req_type_o,
  output logic [`L15_ADDR_W-1:0]    l15_req_addr_o,
  output logic [`L15_SIZE_W-1:0]    l15_req_size_o,
  output logic                      l15_req_nc_o,
  output logic [`L15_DATA_W-1:0]    l15_req_data_o,
  output l15_pkg::l15_tag_t         l15_req_tag_o,

  input  logic                      l15_rtrn_valid_i,
  input  l15_pkg::l15_tag_t         l15_rtrn_tag_i,
  input  logic [`L15_DATA_W-1:0]    l15_rtrn_data_i,
  input  logic                      l15_rtrn_error_i,
  output mem_req_pkg::mem_resp_t    resp_o,
  output logic                      resp_valid_o,
  input  logic                      resp_ready_i,
  output logic                      l15_rtrn_ready_o
);

  logic is_write;

  assign is_write = (grant_req_i.cmd == mem_req_pkg::MEM_WRITE);

  // Request side
  assign l15_req_valid_o = grant_valid_i;
  assign grant_ready_o   = l15_req_ready_i;
  assign l15_req_type_o  = is_write ? l15_pkg::L15_STORE : l15_pkg::L15_LOAD;
  assign l15_req_addr_o  = grant_req_i.addr;
  assign l15_req_nc_o    = grant_req_i.nc;
  // Stores and uncached accesses are single words
  assign l15_req_size_o  = (grant_req_i.nc || is_write) ? `L15_SIZE_WORD : `L15_SIZE_LINE;
  assign l15_req_data_o  = is_write ? grant_req_i.wdata : '0;
  assign l15_req_tag_o   = '{pid: grant_pid_i, tid: grant_req_i.tid};

  // Return side
  assign resp_valid_o     = l15_rtrn_valid_i;
  assign l15_rtrn_ready_o = resp_ready_i;
  assign resp_o           = '{pid:   l15_rtrn_tag_i.pid,
                              tid:   l15_rtrn_tag_i.tid,
                              rdata: l15_rtrn_data_i,
                              error: l15_rtrn_error_i};

endmodule

/* l15_resp_demux.sv */
/*
  Routes the buffered response to the port named by its port id.
  Payload fields are broadcast, only the valid is steered.
  A response with a port id outside the port range is dropped.
*/
`timescale 1ns/1ps
`include "l15_adapter_settings.svh"

module l15_resp_demux (
  input  logic                    resp_valid_i,
  input  mem_req_pkg::mem_resp_t  resp_i,
  output logic                    resp_ready_o,

  output logic                    port_resp_valid_o [`L15_N_PORTS],
  input  logic                    port_resp_ready_i [`L15_N_PORTS],
  output logic [`L15_TID_W-1:0]   port_resp_tid_o   [`L15_N_PORTS],
  output logic [`L15_DATA_W-1:0]  port_resp_data_o  [`L15_N_PORTS],
  output logic                    port_resp_error_o [`L15_N_PORTS]
);

  localparam int N = `L15_N_PORTS;

  always_comb begin
    resp_ready_o = 1'b1;
    for (int i = 0; i < N; i++) begin
      port_resp_valid_o[i] = resp_valid_i && (resp_i.pid == `L15_PID_W'(i));
      port_resp_tid_o[i]   = resp_i.tid;
      port_resp_data_o[i]  = resp_i.rdata;
      port_resp_error_o[i] = resp_i.error;
      if (resp_i.pid == `L15_PID_W'(i)) begin
        resp_ready_o = port_resp_ready_i[i];
      end
    end
  end

endmodule

/* l15_adapter.sv */
/*
  Links the three cache request ports to one L1.5 request/return channel.
  Each port has a one-deep slot; a full slot holds its ready low until
  granted. Unloaded request latency is one cycle, return latency one cycle.
  One request per port plus one response can be in flight in the adapter.
*/
`timescale 1ns/1ps
`include "l15_adapter_settings.svh"

module l15_adapter (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  // Cache request ports
  input  logic                      port_req_valid_i  [`L15_N_PORTS],
  output logic                      port_req_ready_o  [`L15_N_PORTS],
  input  mem_req_pkg::mem_cmd_e     port_req_cmd_i    [`L15_N_PORTS],
  input  logic [`L15_ADDR_W-1:0]    port_req_addr_i   [`L15_N_PORTS],
  input  logic                      port_req_nc_i     [`L15_N_PORTS],
  input  logic [`L15_TID_W-1:0]     port_req_tid_i    [`L15_N_PORTS],
  input  logic [`L15_DATA_W-1:0]    port_req_wdata_i  [`L15_N_PORTS],

  // Cache response ports
  output logic                      port_resp_valid_o [`L15_N_PORTS],
  input  logic                      port_resp_ready_i [`L15_N_PORTS],
  output logic [`L15_TID_W-1:0]     port_resp_tid_o   [`L15_N_PORTS],
  output logic [`L15_DATA_W-1:0]    port_resp_data_o  [`L15_N_PORTS],
  output logic                      port_resp_error_o [`L15_N_PORTS],

  // L1.5 request channel
  output logic                      l15_req_valid_o,
  input  logic                      l15_req_ready_i,
  output l15_pkg::l15_rqtype_e      l15_req_type_o,
  output logic [`L15_ADDR_W-1:0]    l15_req_addr_o,
  output logic [`L15_SIZE_W-1:0]    l15_req_size_o,
  output logic                      l15_req_nc_o,
  output logic [`L15_DATA_W-1:0]    l15_req_data_o,
  output l15_pkg::l15_tag_t         l15_req_tag_o,

  // L1.5 return channel
  input  logic                      l15_rtrn_valid_i,
  output logic                      l15_rtrn_ready_o,
  input  l15_pkg::l15_tag_t         l15_rtrn_tag_i,
  input  logic [`L15_DATA_W-1:0]    l15_rtrn_data_i,
  input  logic                      l15_rtrn_error_i
);

  logic                    slot_valid [`L15_N_PORTS];
  mem_req_pkg::mem_req_t   slot_req   [`L15_N_PORTS];
  logic                    slot_pop   [`L15_N_PORTS];

  logic                    grant_valid;
  logic                    grant_ready;
  mem_req_pkg::mem_req_t   grant_req;
  logic [`L15_PID_W-1:0]   grant_pid;

  logic                    xl_resp_valid;
  logic                    xl_resp_ready;
  mem_req_pkg::mem_resp_t  xl_resp;
  logic                    rsp_valid;
  logic                    rsp_ready;
  mem_req_pkg::mem_resp_t  rsp;

  // Request slots, written straight from the ports
  for (genvar g = 0; g < `L15_N_PORTS; g++) begin : gen_req_slot
    mem_req_pkg::mem_req_t slot_wdata;

    assign slot_wdata = '{cmd:   port_req_cmd_i[g],
                          addr:  port_req_addr_i[g],
                          nc:    port_req_nc_i[g],
                          tid:   port_req_tid_i[g],
                          wdata: port_req_wdata_i[g]};

    mem_fifo_reg #(
      .fifo_data_t (mem_req_pkg::mem_req_t)
    ) u_req_slot (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .w_i     (port_req_valid_i[g]),
      .wok_o   (port_req_ready_o[g]),
      .wdata_i (slot_wdata),
      .r_i     (slot_pop[g]),
      .rok_o   (slot_valid[g]),
      .rdata_o (slot_req[g])
    );
  end

  l15_req_arbiter u_req_arbiter (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .slot_valid_i (slot_valid),
    .slot_req_i   (slot_req),
    .slot_pop_o   (slot_pop),
    .grant_valid_o(grant_valid),
    .grant_req_o  (grant_req),
    .grant_pid_o  (grant_pid),
    .grant_ready_i(grant_ready)
  );

  l15_xlate u_xlate (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .grant_valid_i   (grant_valid),
    .grant_req_i     (grant_req),
    .grant_pid_i     (grant_pid),
    .grant_ready_o   (grant_ready),
    .l15_req_valid_o (l15_req_valid_o),
    .l15_req_ready_i (l15_req_ready_i),
    .l15_req_type_o  (l15_req_type_o),
    .l15_req_addr_o  (l15_req_addr_o),
    .l15_req_size_o  (l15_req_size_o),
    .l15_req_nc_o    (l15_req_nc_o),
    .l15_req_data_o  (l15_req_data_o),
    .l15_req_tag_o   (l15_req_tag_o),
    .l15_rtrn_valid_i(l15_rtrn_valid_i),
    .l15_rtrn_tag_i  (l15_rtrn_tag_i),
    .l15_rtrn_data_i (l15_rtrn_data_i),
    .l15_rtrn_error_i(l15_rtrn_error_i),
    .resp_o          (xl_resp),
    .resp_valid_o    (xl_resp_valid),
    .resp_ready_i    (xl_resp_ready),
    .l15_rtrn_ready_o(l15_rtrn_ready_o)
  );

  // Response slot, blocks the return channel while full
  mem_fifo_reg #(
    .fifo_data_t (mem_req_pkg::mem_resp_t)
  ) u_resp_slot (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .w_i     (xl_resp_valid),
    .wok_o   (xl_resp_ready),
    .wdata_i (xl_resp),
    .r_i     (rsp_ready),
    .rok_o   (rsp_valid),
    .rdata_o (rsp)
  );

  l15_resp_demux u_resp_demux (
    .resp_valid_i     (rsp_valid),
    .resp_i           (rsp),
    .resp_ready_o     (rsp_ready),
    .port_resp_valid_o(port_resp_valid_o),
    .port_resp_ready_i(port_resp_ready_i),
    .port_resp_tid_o  (port_resp_tid_o),
    .port_resp_data_o (port_resp_data_o),
    .port_resp_error_o(port_resp_error_o)
  );

endmodule

/* l15_adapter_chk.sv */
/*
  Concurrent checks bound to the adapter top level.
  Covers reset state, L1.5 request stability under back-pressure,
  round-robin fairness and response slot timing.
  A waiting port is one whose request slot is full (ready low).
*/
`timescale 1ns/1ps
`include "l15_adapter_settings.svh"

module l15_adapter_chk (
  input logic                   clk_i,
  input logic                   arst_n_i,
  input logic                   port_req_ready_i  [`L15_N_PORTS],
  input logic                   port_resp_valid_i [`L15_N_PORTS],
  input logic                   port_resp_ready_i [`L15_N_PORTS],
  input logic                   l15_req_valid_i,
  input logic                   l15_req_ready_i,
  input l15_pkg::l15_rqtype_e   l15_req_type_i,
  input logic [`L15_ADDR_W-1:0] l15_req_addr_i,
  input logic [`L15_SIZE_W-1:0] l15_req_size_i,
  input logic                   l15_req_nc_i,
  input logic [`L15_DATA_W-1:0] l15_req_data_i,
  input l15_pkg::l15_tag_t      l15_req_tag_i,
  input logic                   l15_rtrn_valid_i,
  input logic                   l15_rtrn_ready_i,
  input l15_pkg::l15_tag_t      l15_rtrn_tag_i
);

  localparam int N = `L15_N_PORTS;

  logic       req_fire;
  logic [3:0] skip_cnt [N];

  assign req_fire = l15_req_valid_i && l15_req_ready_i;

  // Grants to other ports while this port's slot is full
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < N; i++) begin
        skip_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N; i++) begin
        if (port_req_ready_i[i]) begin
          skip_cnt[i] <= '0;
        end else if (req_fire && (l15_req_tag_i.pid != `L15_PID_W'(i)) &&
                     (skip_cnt[i] != 4'hf)) begin
          skip_cnt[i] <= skip_cnt[i] + 4'd1;
        end
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !l15_req_valid_i && l15_rtrn_ready_i)
    else $error("L1.5 channel not idle after reset");

  a_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    l15_req_valid_i && !l15_req_ready_i |=> l15_req_valid_i &&
      $stable(l15_req_type_i) && $stable(l15_req_addr_i) && $stable(l15_req_size_i) &&
      $stable(l15_req_nc_i) && $stable(l15_req_data_i) && $stable(l15_req_tag_i))
    else $error("L1.5 request changed while stalled");

  for (genvar g = 0; g < N; g++) begin : gen_port_chk
    a_reset_port: assert property (@(posedge clk_i)
      $rose(arst_n_i) |-> !port_resp_valid_i[g] && port_req_ready_i[g])
      else $error("Port %0d not idle after reset", g);

    a_fair: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      skip_cnt[g] <= 4'(N))
      else $error("Port %0d starved by round-robin", g);

    // Accepted return shows up on its port one cycle later
    a_rtrn_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      l15_rtrn_valid_i && l15_rtrn_ready_i && (l15_rtrn_tag_i.pid == `L15_PID_W'(g))
      |=> port_resp_valid_i[g])
      else $error("Response for port %0d not presented after one cycle", g);

    a_rtrn_blocked: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      port_resp_valid_i[g] && !port_resp_ready_i[g] |-> !l15_rtrn_ready_i)
      else $error("Return channel ready while port %0d holds a response", g);
  end

endmodule

bind l15_adapter l15_adapter_chk u_l15_adapter_chk (
  .clk_i            (clk_i),
  .arst_n_i         (arst_n_i),
  .port_req_ready_i (port_req_ready_o),
  .port_resp_valid_i(port_resp_valid_o),
  .port_resp_ready_i(port_resp_ready_i),
  .l15_req_valid_i  (l15_req_valid_o),
  .l15_req_ready_i  (l15_req_ready_i),
  .l15_req_type_i   (l15_req_type_o),
  .l15_req_addr_i   (l15_req_addr_o),
  .l15_req_size_i   (l15_req_size_o),
  .l15_req_nc_i     (l15_req_nc_o),
  .l15_req_data_i   (l15_req_data_o),
  .l15_req_tag_i    (l15_req_tag_o),
  .l15_rtrn_valid_i (l15_rtrn_valid_i),
  .l15_rtrn_ready_i (l15_rtrn_ready_o),
  .l15_rtrn_tag_i   (l15_rtrn_tag_i)
);

/* tb_l15_adapter.sv */
/*
  Testbench for the L1.5 adapter.
  Inputs change 1 ns after the rising edge, outputs are sampled on the
  falling edge. The L1.5 model returns requests in order with
  data = address ^ RDATA_XOR and error = address bit 39.
*/
`timescale 1ns/1ps
`include "l15_adapter_settings.svh"

module tb_l15_adapter;

  localparam int N         = `L15_N_PORTS;
  localparam int REQS      = 40;
  localparam int TIMEOUT   = 200;
  localparam logic [`L15_DATA_W-1:0] RDATA_XOR = 64'ha5c3_0f96_5a3c_f069;

  logic                          clk_i;
  logic                          arst_n_i;
  logic                          port_req_valid_i  [N];
  logic                          port_req_ready_o  [N];
  mem_req_pkg::mem_cmd_e         port_req_cmd_i    [N];
  logic [`L15_ADDR_W-1:0]        port_req_addr_i   [N];
  logic                          port_req_nc_i     [N];
  logic [`L15_TID_W-1:0]         port_req_tid_i    [N];
  logic [`L15_DATA_W-1:0]        port_req_wdata_i  [N];
  logic                          port_resp_valid_o [N];
  logic                          port_resp_ready_i [N];
  logic [`L15_TID_W-1:0]         port_resp_tid_o   [N];
  logic [`L15_DATA_W-1:0]        port_resp_data_o  [N];
  logic                          port_resp_error_o [N];
  logic                          l15_req_valid_o;
  logic                          l15_req_ready_i;
  l15_pkg::l15_rqtype_e          l15_req_type_o;
  logic [`L15_ADDR_W-1:0]        l15_req_addr_o;
  logic [`L15_SIZE_W-1:0]        l15_req_size_o;
  logic                          l15_req_nc_o;
  logic [`L15_DATA_W-1:0]        l15_req_data_o;
  l15_pkg::l15_tag_t             l15_req_tag_o;
  logic                          l15_rtrn_valid_i;
  logic                          l15_rtrn_ready_o;
  l15_pkg::l15_tag_t             l15_rtrn_tag_i;
  logic [`L15_DATA_W-1:0]        l15_rtrn_data_i;
  logic                          l15_rtrn_error_i;

  logic [31:0]                   lcg_state;
  int                            resp_count;
  mem_req_pkg::mem_req_t         sent_q [N][$];
  mem_req_pkg::mem_resp_t        exp_q  [N][$];
  l15_pkg::l15_tag_t             rtrn_tag_q[$];
  logic [`L15_ADDR_W-1:0]        rtrn_addr_q[$];

  l15_adapter u_l15_adapter (.*);

  always #4 clk_i = ~clk_i;

  // Upper state bits are swapped down, the low LCG bits repeat quickly
  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      $display("Regression failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic report_error(input string what);
    $display("ERROR %s", what);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic record_port_request(input int p);
    mem_req_pkg::mem_req_t rec;
    rec.cmd   = port_req_cmd_i[p];
    rec.addr  = port_req_addr_i[p];
    rec.nc    = port_req_nc_i[p];
    rec.tid   = port_req_tid_i[p];
    rec.wdata = port_req_wdata_i[p];
    sent_q[p].push_back(rec);
  endtask

  task automatic check_l15_request();
    mem_req_pkg::mem_req_t  exp;
    mem_req_pkg::mem_resp_t resp;
    l15_pkg::l15_rqtype_e   exp_type;
    logic [`L15_SIZE_W-1:0] exp_size;
    int                     p;
    p = int'(l15_req_tag_o.pid);
    if (p >= N) begin
      report_error("L1.5 request tag names a port that does not exist");
    end
    if (sent_q[p].size() == 0) begin
      report_error("L1.5 request for a port that sent nothing");
    end
    exp      = sent_q[p].pop_front();
    exp_type = (exp.cmd == mem_req_pkg::MEM_WRITE) ? l15_pkg::L15_STORE : l15_pkg::L15_LOAD;
    exp_size = (exp.nc || exp.cmd == mem_req_pkg::MEM_WRITE) ? `L15_SIZE_WORD
                                                               : `L15_SIZE_LINE;
    compare_value("req_type", exp_type, l15_req_type_o);
    compare_value("req_size", exp_size, l15_req_size_o);
    compare_value("req_nc", exp.nc, l15_req_nc_o);
    compare_value("req_addr", exp.addr, l15_req_addr_o);
    compare_value("req_tid", exp.tid, l15_req_tag_o.tid);
    if (exp.cmd == mem_req_pkg::MEM_WRITE) begin
      compare_value("req_wdata", exp.wdata, l15_req_data_o);
    end
    rtrn_tag_q.push_back(l15_req_tag_o);
    rtrn_addr_q.push_back(l15_req_addr_o);
    resp.pid   = l15_req_tag_o.pid;
    resp.tid   = exp.tid;
    resp.rdata = {24'd0, exp.addr} ^ RDATA_XOR;
    resp.error = exp.addr[39];
    exp_q[p].push_back(resp);
  endtask

  task automatic check_port_response(input int p);
    mem_req_pkg::mem_resp_t exp;
    if (exp_q[p].size() == 0) begin
      report_error("response arrived on a port with nothing outstanding");
    end
    exp = exp_q[p].pop_front();
    compare_value("resp_tid", exp.tid, port_resp_tid_o[p]);
    compare_value("resp_data", exp.rdata, port_resp_data_o[p]);
    compare_value("resp_error", exp.error, port_resp_error_o[p]);
    resp_count++;
  endtask

  // Mid-cycle sampling, every handshake seen here completes at the next edge
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      for (int p = 0; p < N; p++) begin
        if (port_req_valid_i[p] && port_req_ready_o[p]) begin
          record_port_request(p);
        end
        if (port_resp_valid_o[p] && port_resp_ready_i[p]) begin
          check_port_response(p);
        end
      end
      if (l15_req_valid_o && l15_req_ready_i) begin
        check_l15_request();
      end
    end
  end

  task automatic send_requests(input int p);
    logic [31:0] r;
    logic [31:0] a;
    int          wait_cnt;
    for (int k = 0; k < REQS; k++) begin
      r = rand_next();
      a = rand_next();
      // First request of every port starts together
      repeat ((k == 0) ? 0 : int'(r[1:0])) begin
        @(posedge clk_i);
        #1;
      end
      port_req_cmd_i[p]   = (p == 2) ? mem_req_pkg::MEM_WRITE : mem_req_pkg::MEM_READ;
      port_req_addr_i[p]  = {r[15:8], a};
      port_req_nc_i[p]    = r[2];
      port_req_tid_i[p]   = k[3:0];
      port_req_wdata_i[p] = {a, r};
      port_req_valid_i[p] = 1'b1;
      wait_cnt = 0;
      @(negedge clk_i);
      while (!port_req_ready_o[p]) begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT) begin
          report_error("timeout waiting for port request ready");
        end
        @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
      port_req_valid_i[p] = 1'b0;
    end
  endtask

  // L1.5 model, answers in request order
  task automatic run_responder();
    logic [31:0]            r;
    logic [`L15_ADDR_W-1:0] addr;
    int                     wait_cnt;
    forever begin
      if (rtrn_tag_q.size() == 0) begin
        @(posedge clk_i);
        #1;
      end else begin
        r = rand_next();
        repeat (int'(r[1:0])) begin
          @(posedge clk_i);
          #1;
        end
        addr             = rtrn_addr_q.pop_front();
        l15_rtrn_tag_i   = rtrn_tag_q.pop_front();
        l15_rtrn_data_i  = {24'd0, addr} ^ RDATA_XOR;
        l15_rtrn_error_i = addr[39];
        l15_rtrn_valid_i = 1'b1;
        wait_cnt = 0;
        @(negedge clk_i);
        while (!l15_rtrn_ready_o) begin
          wait_cnt++;
          if (wait_cnt > TIMEOUT) begin
            report_error("timeout waiting for L1.5 return ready");
          end
          @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        l15_rtrn_valid_i = 1'b0;
      end
    end
  endtask

  task automatic drive_ready_gaps();
    logic [31:0] r;
    forever begin
      @(posedge clk_i);
      #1;
      r = rand_next();
      l15_req_ready_i = (r[1:0] != 2'b00);
      for (int p = 0; p < N; p++) begin
        port_resp_ready_i[p] = (r[2*p+2 +: 2] != 2'b00);
      end
    end
  endtask

  initial begin
    int wait_cnt;
    int leftover;
    lcg_state        = 32'd81;
    resp_count       = 0;
    clk_i            = 1'b0;
    arst_n_i         = 1'b0;
    l15_req_ready_i  = 1'b0;
    l15_rtrn_valid_i = 1'b0;
    l15_rtrn_tag_i   = '0;
    l15_rtrn_data_i  = '0;
    l15_rtrn_error_i = 1'b0;
    for (int p = 0; p < N; p++) begin
      port_req_valid_i[p]  = 1'b0;
      port_req_cmd_i[p]    = mem_req_pkg::MEM_READ;
      port_req_addr_i[p]   = '0;
      port_req_nc_i[p]     = 1'b0;
      port_req_tid_i[p]    = '0;
      port_req_wdata_i[p]  = '0;
      port_resp_ready_i[p] = 1'b0;
    end
    repeat (4) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    fork
      run_responder();
      drive_ready_gaps();
    join_none
    fork
      send_requests(0);
      send_requests(1);
      send_requests(2);
    join
    wait_cnt = 0;
    while (resp_count < N * REQS) begin
      wait_cnt++;
      if (wait_cnt > TIMEOUT * 10) begin
        report_error("timeout waiting for all responses");
      end
      @(posedge clk_i);
    end
    leftover = rtrn_tag_q.size();
    for (int p = 0; p < N; p++) begin
      leftover += sent_q[p].size() + exp_q[p].size();
    end
    if (leftover == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("ERROR %0d transactions left unmatched", leftover);
      $display("Regression failed");
      $fatal(1, "stopped with unmatched transactions");
    end
  end

endmodule

/* l15_adapter.f */
+incdir+.
mem_req_pkg.sv
l15_pkg.sv
mem_fifo_reg.sv
l15_req_arbiter.sv
l15_xlate.sv
l15_resp_demux.sv
l15_adapter.sv
l15_adapter_chk.sv
tb_l15_adapter.sv

/* Makefile */
# Verilator build for the L1.5 adapter
VERILATOR ?= verilator
TB_TOP    := tb_l15_adapter
RTL_TOP   := l15_adapter
FILELIST  := l15_adapter.f
OBJDIR    := obj_dir
LINTFLAGS := --lint-only --timing --assert
SIMFLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

# The simulator exit status carries pass or fail
sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJDIR)
